// ==== Bender.yml ====
package:
  name: dram_wrapper

sources:
  - files:
      - design/dram_pkg.sv
      - design/dram_dw_resizer.sv
      - design/dram_id_remapper.sv
      - design/dram_mem_model.sv
      - design/dram_wrapper.sv
  - target: test
    files:
      - dv/dram_wrapper_assertions.sv
      - dv/tb_dram_wrapper.sv

// ==== design/dram_dw_resizer.sv ====
// Data width resizer
`timescale 1ns/1ps
`default_nettype none

module dram_dw_resizer #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  input  dram_pkg::soc_req_t   slv_req_i,
  input  logic                 slv_req_valid_i,
  output logic                 slv_req_ready_o,
  output dram_pkg::soc_rsp_t   slv_rsp_o,
  output logic                 slv_rsp_valid_o,
  input  logic                 slv_rsp_ready_i,
  output dram_pkg::dram_req_t  mst_req_o,
  output logic                 mst_req_valid_o,
  input  logic                 mst_req_ready_i,
  input  dram_pkg::dram_rsp_t  mst_rsp_i,
  input  logic                 mst_rsp_valid_i,
  output logic                 mst_rsp_ready_o
);

  localparam int unsigned PtrWidth  = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int unsigned IdHiWidth = dram_pkg::SocIdWidth - dram_pkg::DramIdWidth;

  // Lane bit plus the ID bits the controller side cannot carry
  typedef struct packed {
    logic [IdHiWidth-1:0] id_hi;
    logic                 lane;
  } lane_entry_t;

  lane_entry_t         fifo_q [MaxTxns];
  lane_entry_t         push_entry;
  lane_entry_t         head;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                fifo_full;
  logic                push;
  logic                pop;

  assign push_entry.id_hi = slv_req_i.id[dram_pkg::SocIdWidth-1:dram_pkg::DramIdWidth];
  assign push_entry.lane  = slv_req_i.addr[2];
  assign head             = fifo_q[rd_ptr_q];

  ////////////////////
  // Request side
  ////////////////////

  assign fifo_full       = (count_q == (PtrWidth + 1)'(MaxTxns));
  assign mst_req_valid_o = slv_req_valid_i && !fifo_full;
  assign slv_req_ready_o = mst_req_ready_i && !fifo_full;
  assign push            = slv_req_valid_i && slv_req_ready_o;

  always_comb begin
    mst_req_o.write                    = slv_req_i.write;
    mst_req_o.addr                     = slv_req_i.addr;
    mst_req_o.id                       = slv_req_i.id[dram_pkg::DramIdWidth-1:0];
    mst_req_o.data.word                = '0;
    mst_req_o.data.lane[push_entry.lane] = slv_req_i.data;
    mst_req_o.strb                     = '0;
    // Strobe moves into the byte slots of the chosen lane
    mst_req_o.strb[push_entry.lane*dram_pkg::SocStrbWidth +: dram_pkg::SocStrbWidth] =
        slv_req_i.strb;
  end

  ////////////////////
  // Response side
  ////////////////////

  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;
  assign pop             = mst_rsp_valid_i && slv_rsp_ready_i;
  assign slv_rsp_o.id    = {head.id_hi, mst_rsp_i.id};
  assign slv_rsp_o.data  = mst_rsp_i.data.lane[head.lane];

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(MaxTxns - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MaxTxns - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= push_entry;
    end
  end

endmodule

`default_nettype wire

// ==== design/dram_id_remapper.sv ====
// Transaction ID remapper
`timescale 1ns/1ps
`default_nettype none

module dram_id_remapper #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  input  dram_pkg::dram_req_t  slv_req_i,
  input  logic                 slv_req_valid_i,
  output logic                 slv_req_ready_o,
  output dram_pkg::dram_rsp_t  slv_rsp_o,
  output logic                 slv_rsp_valid_o,
  input  logic                 slv_rsp_ready_i,
  output dram_pkg::dram_req_t  mst_req_o,
  output logic                 mst_req_valid_o,
  input  logic                 mst_req_ready_i,
  input  dram_pkg::dram_rsp_t  mst_rsp_i,
  input  logic                 mst_rsp_valid_i,
  output logic                 mst_rsp_ready_o
);

  localparam int unsigned NumSlots = 2 ** dram_pkg::DramIdWidth;
  localparam int unsigned CntWidth = $clog2(NumSlots + 1);

  logic [NumSlots-1:0]              busy_q;
  logic [dram_pkg::DramIdWidth-1:0] id_tbl_q [NumSlots];
  logic [dram_pkg::DramIdWidth-1:0] free_slot;
  logic [CntWidth-1:0]              busy_cnt;
  logic                             any_free;
  logic                             can_issue;
  logic                             req_fire;
  logic                             rsp_fire;

  ////////////////////
  // Slot allocation
  ////////////////////

  // Downward scan leaves the lowest free slot selected
  always_comb begin
    free_slot = '0;
    any_free  = 1'b0;
    busy_cnt  = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_slot = dram_pkg::DramIdWidth'(i);
        any_free  = 1'b1;
      end
      busy_cnt = busy_cnt + CntWidth'(busy_q[i]);
    end
  end

  assign can_issue       = any_free && (32'(busy_cnt) < MaxTxns);
  assign mst_req_valid_o = slv_req_valid_i && can_issue;
  assign slv_req_ready_o = mst_req_ready_i && can_issue;
  assign req_fire        = slv_req_valid_i && slv_req_ready_o;

  always_comb begin
    mst_req_o    = slv_req_i;
    mst_req_o.id = free_slot;
  end

  ////////////////////
  // Response restore
  ////////////////////

  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;
  assign rsp_fire        = mst_rsp_valid_i && slv_rsp_ready_i;
  assign slv_rsp_o.id    = id_tbl_q[mst_rsp_i.id];
  assign slv_rsp_o.data  = mst_rsp_i.data;

  // Allocated and released slots never coincide
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= '0;
    end else begin
      if (req_fire) begin
        busy_q[free_slot] <= 1'b1;
      end
      if (rsp_fire) begin
        busy_q[mst_rsp_i.id] <= 1'b0;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (req_fire) begin
      id_tbl_q[free_slot] <= slv_req_i.id;
    end
  end

endmodule

`default_nettype wire

// ==== design/dram_mem_model.sv ====
// Fixed-latency DRAM controller model
`timescale 1ns/1ps
`default_nettype none

module dram_mem_model #(
  parameter int unsigned DramAddrWidth = 10,
  parameter int unsigned MemLatency    = 3
) (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  input  dram_pkg::dram_req_t  req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output dram_pkg::dram_rsp_t  rsp_o,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i
);

  localparam int unsigned Depth = 2 ** DramAddrWidth;

  dram_pkg::dram_word_u     mem_q [Depth];
  dram_pkg::dram_rsp_t      stage_q [MemLatency];
  dram_pkg::dram_rsp_t      new_rsp;
  logic [MemLatency-1:0]    valid_q;
  logic [DramAddrWidth-1:0] word_idx;
  logic                     stall;
  logic                     req_fire;

  // Upper address bits fall off, so those addresses alias
  assign word_idx    = req_i.addr[DramAddrWidth+2:3];
  assign stall       = valid_q[MemLatency-1] && !rsp_ready_i;
  assign req_ready_o = !stall;
  assign req_fire    = req_valid_i && req_ready_o;

  // Writes answer with zero data
  assign new_rsp.id        = req_i.id;
  assign new_rsp.data.word = req_i.write ? '0 : mem_q[word_idx].word;

  ////////////////////
  // Response pipeline
  ////////////////////

  // Whole pipe holds while the last stage waits
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= req_fire;
      for (int s = 1; s < MemLatency; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (!stall) begin
      stage_q[0] <= new_rsp;
      for (int s = 1; s < MemLatency; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign rsp_o       = stage_q[MemLatency-1];
  assign rsp_valid_o = valid_q[MemLatency-1];

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge soc_clk_i) begin
    if (req_fire && req_i.write) begin
      for (int b = 0; b < dram_pkg::DramStrbWidth; b++) begin
        if (req_i.strb[b]) begin
          mem_q[word_idx].word[8*b +: 8] <= req_i.data.word[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dram_pkg.sv ====
// DRAM path shared types
`default_nettype none

package dram_pkg;

  // Bus widths on both sides of the resizer
  localparam int unsigned SocDataWidth  = 32;
  localparam int unsigned DramDataWidth = 64;
  localparam int unsigned SocStrbWidth  = SocDataWidth / 8;
  localparam int unsigned DramStrbWidth = DramDataWidth / 8;
  localparam int unsigned NumLanes      = DramDataWidth / SocDataWidth;
  localparam int unsigned SocIdWidth    = 4;
  localparam int unsigned DramIdWidth   = 2;
  localparam int unsigned AddrWidth     = 32;

  // Single-beat SoC request
  typedef struct packed {
    logic                    write;
    logic [AddrWidth-1:0]    addr;
    logic [SocIdWidth-1:0]   id;
    logic [SocDataWidth-1:0] data;
    logic [SocStrbWidth-1:0] strb;
  } soc_req_t;

  typedef struct packed {
    logic [SocIdWidth-1:0]   id;
    logic [SocDataWidth-1:0] data;
  } soc_rsp_t;

  // Controller word, seen whole or as two 32-bit lanes
  typedef union packed {
    logic [DramDataWidth-1:0]               word;
    logic [NumLanes-1:0][SocDataWidth-1:0]  lane;
  } dram_word_u;

  typedef struct packed {
    logic                     write;
    logic [AddrWidth-1:0]     addr;
    logic [DramIdWidth-1:0]   id;
    dram_word_u               data;
    logic [DramStrbWidth-1:0] strb;
  } dram_req_t;

  typedef struct packed {
    logic [DramIdWidth-1:0] id;
    dram_word_u             data;
  } dram_rsp_t;

endpackage

`default_nettype wire

// ==== design/dram_wrapper.sv ====
// SoC to DRAM memory path
`timescale 1ns/1ps
`default_nettype none

module dram_wrapper #(
  parameter int unsigned DramAddrWidth = 10,
  parameter int unsigned MaxTxns       = 4,
  parameter int unsigned MemLatency    = 3
) (
  input  logic                soc_clk_i,
  input  logic                arst_n_i,
  input  dram_pkg::soc_req_t  soc_req_i,
  input  logic                soc_req_valid_i,
  output logic                soc_req_ready_o,
  output dram_pkg::soc_rsp_t  soc_rsp_o,
  output logic                soc_rsp_valid_o,
  input  logic                soc_rsp_ready_i
);

  // Resizer to remapper
  dram_pkg::dram_req_t dw_req;
  dram_pkg::dram_rsp_t dw_rsp;
  logic                dw_req_valid, dw_req_ready;
  logic                dw_rsp_valid, dw_rsp_ready;

  // Remapper to memory model
  dram_pkg::dram_req_t mem_req;
  dram_pkg::dram_rsp_t mem_rsp;
  logic                mem_req_valid, mem_req_ready;
  logic                mem_rsp_valid, mem_rsp_ready;

  dram_dw_resizer #(
    .MaxTxns ( MaxTxns )
  ) i_dw_resizer (
    .soc_clk_i       ( soc_clk_i       ),
    .arst_n_i        ( arst_n_i        ),
    .slv_req_i       ( soc_req_i       ),
    .slv_req_valid_i ( soc_req_valid_i ),
    .slv_req_ready_o ( soc_req_ready_o ),
    .slv_rsp_o       ( soc_rsp_o       ),
    .slv_rsp_valid_o ( soc_rsp_valid_o ),
    .slv_rsp_ready_i ( soc_rsp_ready_i ),
    .mst_req_o       ( dw_req          ),
    .mst_req_valid_o ( dw_req_valid    ),
    .mst_req_ready_i ( dw_req_ready    ),
    .mst_rsp_i       ( dw_rsp          ),
    .mst_rsp_valid_i ( dw_rsp_valid    ),
    .mst_rsp_ready_o ( dw_rsp_ready    )
  );

  dram_id_remapper #(
    .MaxTxns ( MaxTxns )
  ) i_id_remapper (
    .soc_clk_i       ( soc_clk_i     ),
    .arst_n_i        ( arst_n_i      ),
    .slv_req_i       ( dw_req        ),
    .slv_req_valid_i ( dw_req_valid  ),
    .slv_req_ready_o ( dw_req_ready  ),
    .slv_rsp_o       ( dw_rsp        ),
    .slv_rsp_valid_o ( dw_rsp_valid  ),
    .slv_rsp_ready_i ( dw_rsp_ready  ),
    .mst_req_o       ( mem_req       ),
    .mst_req_valid_o ( mem_req_valid ),
    .mst_req_ready_i ( mem_req_ready ),
    .mst_rsp_i       ( mem_rsp       ),
    .mst_rsp_valid_i ( mem_rsp_valid ),
    .mst_rsp_ready_o ( mem_rsp_ready )
  );

  dram_mem_model #(
    .DramAddrWidth ( DramAddrWidth ),
    .MemLatency    ( MemLatency    )
  ) i_mem_model (
    .soc_clk_i   ( soc_clk_i     ),
    .arst_n_i    ( arst_n_i      ),
    .req_i       ( mem_req       ),
    .req_valid_i ( mem_req_valid ),
    .req_ready_o ( mem_req_ready ),
    .rsp_o       ( mem_rsp       ),
    .rsp_valid_o ( mem_rsp_valid ),
    .rsp_ready_i ( mem_rsp_ready )
  );

endmodule

`default_nettype wire

// ==== dv/dram_wrapper_assertions.sv ====
// DRAM path protocol checks
`timescale 1ns/1ps
`default_nettype none

module dram_wrapper_assertions #(
  parameter int unsigned MaxTxns = 4
) (
  input wire logic               soc_clk_i,
  input wire logic               arst_n_i,
  input wire dram_pkg::soc_req_t soc_req_i,
  input wire logic               soc_req_valid_i,
  input wire logic               soc_req_ready_o,
  input wire dram_pkg::soc_rsp_t soc_rsp_o,
  input wire logic               soc_rsp_valid_o,
  input wire logic               soc_rsp_ready_i
);

  logic req_fire;
  logic rsp_fire;
  int   outstanding_q;

  assign req_fire = soc_req_valid_i && soc_req_ready_o;
  assign rsp_fire = soc_rsp_valid_o && soc_rsp_ready_i;

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(req_fire) - int'(rsp_fire);
    end
  end

  ////////////////////
  // Handshake rules
  ////////////////////

  req_stable_a : assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_req_valid_i && !soc_req_ready_o |=> soc_req_valid_i && $stable(soc_req_i))
    else $error("request changed while waiting for ready");

  rsp_stable_a : assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_rsp_valid_o && !soc_rsp_ready_i |=> soc_rsp_valid_o && $stable(soc_rsp_o))
    else $error("response changed while waiting for ready");

  // A response needs a request still in flight
  rsp_after_req_a : assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    rsp_fire |-> outstanding_q > 0)
    else $error("more responses than requests");

  max_txns_a : assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    outstanding_q <= MaxTxns)
    else $error("outstanding limit exceeded");

endmodule

bind dram_wrapper dram_wrapper_assertions #(
  .MaxTxns ( MaxTxns )
) i_wrapper_assertions (
  .soc_clk_i       ( soc_clk_i       ),
  .arst_n_i        ( arst_n_i        ),
  .soc_req_i       ( soc_req_i       ),
  .soc_req_valid_i ( soc_req_valid_i ),
  .soc_req_ready_o ( soc_req_ready_o ),
  .soc_rsp_o       ( soc_rsp_o       ),
  .soc_rsp_valid_o ( soc_rsp_valid_o ),
  .soc_rsp_ready_i ( soc_rsp_ready_i )
);

`default_nettype wire

// ==== dv/tb_dram_wrapper.sv ====
// DRAM path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dram_wrapper;

  localparam int unsigned DramAddrWidth = 10;
  localparam int unsigned MaxTxns       = 4;
  localparam int unsigned MemLatency    = 3;
  localparam int unsigned NumRandom     = 300;
  localparam int unsigned DirectedReqs  = 40;
  localparam int unsigned TimeoutCycles = 10 * (NumRandom + DirectedReqs) * (MemLatency + 2);

  logic               soc_clk_i = 1'b0;
  logic               arst_n_i;
  dram_pkg::soc_req_t soc_req_i;
  logic               soc_req_valid_i;
  logic               soc_req_ready_o;
  dram_pkg::soc_rsp_t soc_rsp_o;
  logic               soc_rsp_valid_o;
  logic               soc_rsp_ready_i = 1'b0;

  logic [31:0]        lfsr_state = 32'd93797;
  logic [31:0]        ref_mem [int unsigned];
  dram_pkg::soc_rsp_t exp_q [$];
  dram_pkg::soc_rsp_t exp_rsp;
  int unsigned        issued_cnt = 0;
  int unsigned        rsp_cnt = 0;
  int unsigned        cycle_cnt = 0;
  // 0 always ready, 1 held low, 2 random
  int unsigned        bp_mode = 0;
  logic               bp_bit;

  dram_wrapper #(
    .DramAddrWidth ( DramAddrWidth ),
    .MaxTxns       ( MaxTxns       ),
    .MemLatency    ( MemLatency    )
  ) dut_i (
    .soc_clk_i       ( soc_clk_i       ),
    .arst_n_i        ( arst_n_i        ),
    .soc_req_i       ( soc_req_i       ),
    .soc_req_valid_i ( soc_req_valid_i ),
    .soc_req_ready_o ( soc_req_ready_o ),
    .soc_rsp_o       ( soc_rsp_o       ),
    .soc_rsp_valid_o ( soc_rsp_valid_o ),
    .soc_rsp_ready_i ( soc_rsp_ready_i )
  );

  always #20 soc_clk_i = ~soc_clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic dram_pkg::soc_req_t make_req(input logic w, input logic [31:0] addr,
                                                  input logic [31:0] data,
                                                  input logic [3:0] strb,
                                                  input logic [3:0] id);
    dram_pkg::soc_req_t r;
    r.write = w;
    r.addr  = addr;
    r.id    = id;
    r.data  = data;
    r.strb  = strb;
    return r;
  endfunction

  // Storage is keyed by the 32-bit lane word the controller decodes
  function automatic dram_pkg::soc_rsp_t ref_access(input dram_pkg::soc_req_t r);
    dram_pkg::soc_rsp_t rsp;
    int unsigned        key;
    logic [31:0]        word;
    key      = (r.addr >> 2) % (32'd1 << (DramAddrWidth + 1));
    word     = ref_mem.exists(key) ? ref_mem[key] : 'x;
    rsp.id   = r.id;
    rsp.data = word;
    if (r.write) begin
      for (int b = 0; b < 4; b++) begin
        if (r.strb[b]) begin
          word[8*b +: 8] = r.data[8*b +: 8];
        end
      end
      ref_mem[key] = word;
      rsp.data     = '0;
    end
    return rsp;
  endfunction

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_failed();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic record_accept(input dram_pkg::soc_req_t req);
    exp_q.push_back(ref_access(req));
    issued_cnt++;
  endtask

  task automatic send_req(input dram_pkg::soc_req_t req);
    soc_req_i       = req;
    soc_req_valid_i = 1'b1;
    @(posedge soc_clk_i);
    while (!soc_req_ready_o) begin
      @(posedge soc_clk_i);
    end
    record_accept(req);
    #2;
    soc_req_valid_i = 1'b0;
  endtask

  ////////////////////
  // Test sequences
  ////////////////////

  task automatic run_directed();
    logic [31:0] base;
    logic [31:0] alias_addr;
    base       = 32'h0000_0040;
    alias_addr = base | (32'hFFFF_FFFF << (DramAddrWidth + 3));
    // Lower and upper lane of one controller word
    send_req(make_req(1'b1, base, 32'h1122_3344, 4'hF, 4'(rand_bits(4))));
    send_req(make_req(1'b1, base + 4, 32'h5566_7788, 4'hF, 4'(rand_bits(4))));
    send_req(make_req(1'b0, base, '0, '0, 4'(rand_bits(4))));
    send_req(make_req(1'b0, base + 4, '0, '0, 4'(rand_bits(4))));
    // Partial strobes
    send_req(make_req(1'b1, base, 32'hAABB_CCDD, 4'b0101, 4'(rand_bits(4))));
    send_req(make_req(1'b1, base + 4, 32'h99EE_FF00, 4'b1010, 4'(rand_bits(4))));
    send_req(make_req(1'b0, base, '0, '0, 4'(rand_bits(4))));
    send_req(make_req(1'b0, base + 4, '0, '0, 4'(rand_bits(4))));
    // High address bits alias onto the same word
    send_req(make_req(1'b1, alias_addr, 32'hDEAD_BEEF, 4'b0011, 4'(rand_bits(4))));
    send_req(make_req(1'b0, base, '0, '0, 4'(rand_bits(4))));
    send_req(make_req(1'b0, alias_addr, '0, '0, 4'(rand_bits(4))));
  endtask

  task automatic run_backpressure();
    dram_pkg::soc_req_t req;
    int unsigned        accepted;
    accepted = 0;
    wait (exp_q.size() == 0);
    bp_mode = 1;
    repeat (2) @(posedge soc_clk_i);
    #2;
    req             = make_req(1'b0, 32'h0000_0040, '0, '0, 4'(rand_bits(4)));
    soc_req_i       = req;
    soc_req_valid_i = 1'b1;
    repeat (12) begin
      @(posedge soc_clk_i);
      if (soc_req_ready_o) begin
        record_accept(req);
        accepted++;
        #2;
        req       = make_req(1'b0, 32'h0000_0044, '0, '0, 4'(rand_bits(4)));
        soc_req_i = req;
      end
    end
    if (accepted == 0 || accepted > MaxTxns) begin
      fail_run($sformatf("%0d requests accepted while responses were held", accepted));
    end
    check_value("soc_req_ready_o", 32'(soc_req_ready_o), 32'd0);
    bp_mode = 0;
    @(posedge soc_clk_i);
    while (!soc_req_ready_o) begin
      @(posedge soc_clk_i);
    end
    record_accept(req);
    #2;
    soc_req_valid_i = 1'b0;
  endtask

  task automatic run_random();
    logic [31:0] addr;
    // Fill the address pool so every read hits known data
    for (int unsigned i = 0; i < 16; i++) begin
      send_req(make_req(1'b1, i << 2, rand_bits(32), 4'hF, 4'(rand_bits(4))));
    end
    bp_mode = 2;
    for (int unsigned n = 0; n < NumRandom; n++) begin
      addr = (rand_bits(32 - DramAddrWidth - 3) << (DramAddrWidth + 3)) | (rand_bits(4) << 2);
      send_req(make_req(1'(rand_bits(1)), addr, rand_bits(32), 4'(rand_bits(4)),
                        4'(rand_bits(4))));
      if (rand_bits(1)) begin
        @(posedge soc_clk_i);
        #2;
      end
    end
  endtask

  ////////////////////
  // Processes
  ////////////////////

  always begin
    @(posedge soc_clk_i);
    #1;
    bp_bit = (rand_bits(2) != 0);
    #1;
    soc_rsp_ready_i = (bp_mode == 0) ? 1'b1 : (bp_mode == 1) ? 1'b0 : bp_bit;
  end

  always @(posedge soc_clk_i) begin
    if (arst_n_i && soc_rsp_valid_o && soc_rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        fail_run("response arrived with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_value("soc_rsp_o.id", 32'(soc_rsp_o.id), 32'(exp_rsp.id));
        check_value("soc_rsp_o.data", soc_rsp_o.data, exp_rsp.data);
        rsp_cnt++;
      end
    end
  end

  always @(posedge soc_clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run($sformatf("run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  initial begin
    arst_n_i        = 1'b0;
    soc_req_i       = '0;
    soc_req_valid_i = 1'b0;
    repeat (4) @(posedge soc_clk_i);
    #2;
    arst_n_i = 1'b1;
    @(posedge soc_clk_i);
    #2;
    run_directed();
    run_backpressure();
    run_random();
    bp_mode = 0;
    wait (exp_q.size() == 0);
    repeat (4) @(posedge soc_clk_i);
    // Drained path must be idle and ready again
    if (!soc_rsp_valid_o && soc_req_ready_o) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_run($sformatf("DUT not idle after %0d responses to %0d requests", rsp_cnt,
                         issued_cnt));
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/dram_pkg.sv
design/dram_dw_resizer.sv
design/dram_id_remapper.sv
design/dram_mem_model.sv
design/dram_wrapper.sv
dv/dram_wrapper_assertions.sv
dv/tb_dram_wrapper.sv
